/* rv_isa_pkg.sv */
/*
 * RV64I subset ISA definitions
 * Data and instruction widths, major opcodes, funct codes
 * and the ALU operation set of the integer pipeline
 */
`default_nettype none

package rv_isa_pkg;

   localparam int XLEN       = 64;
   localparam int INSTR_W    = 32;
   localparam int REG_ADDR_W = 5;

   typedef logic [XLEN-1:0]       xlen_t;
   typedef logic [INSTR_W-1:0]    instr_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Major opcodes
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   localparam logic [2:0] F3_ADD_SUB = 3'b000; // add, sub, addi
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [2:0] F3_DWORD   = 3'b011; // ld and sd

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_SUB  = 7'b0100000;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR
   } alu_op_e;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
/*
 * Pipeline payload types
 * Control bundle, the stage-to-stage registers, the write-back
 * offer used for register write and forwarding, and the
 * external memory access request
 */
`default_nettype none

package pipe_pkg;

   // Selects how ALU control reads funct3/funct7
   typedef enum logic [1:0] {
      ALU_CLASS_MEM = 2'b00, // Address add for ld/sd, also the no-op value
      ALU_CLASS_REG = 2'b10,
      ALU_CLASS_IMM = 2'b11
   } alu_class_e;

   typedef struct packed {
      logic       reg_write;
      logic       mem_to_reg;
      logic       mem_read;
      logic       mem_write;
      logic       alu_src;   // Operand B from immediate
      alu_class_e alu_class;
   } ctrl_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      rv_isa_pkg::xlen_t     rs1_data;
      rv_isa_pkg::xlen_t     rs2_data;
      rv_isa_pkg::xlen_t     imm;
      logic [2:0]            funct3;
      logic [6:0]            funct7;
      rv_isa_pkg::reg_addr_t rs1;
      rv_isa_pkg::reg_addr_t rs2;
      rv_isa_pkg::reg_addr_t rd;
   } id_ex_t;

   typedef struct packed {
      ctrl_t                 ctrl;
      rv_isa_pkg::xlen_t     alu_result;
      rv_isa_pkg::xlen_t     store_data;
      rv_isa_pkg::reg_addr_t rs2;
      rv_isa_pkg::reg_addr_t rd;
   } ex_mem_t;

   typedef struct packed {
      logic                  reg_write;
      logic                  mem_to_reg;
      logic                  mem_read;
      rv_isa_pkg::xlen_t     load_data;
      rv_isa_pkg::xlen_t     alu_result;
      rv_isa_pkg::reg_addr_t rd;
   } mem_wb_t;

   // One stage's write-back offer
   typedef struct packed {
      logic                  reg_write;
      rv_isa_pkg::reg_addr_t rd;
      rv_isa_pkg::xlen_t     data;
   } wb_port_t;

   typedef struct packed {
      rv_isa_pkg::xlen_t addr;  // Byte address
      logic              wen;
      logic              ren;
      rv_isa_pkg::xlen_t wdata; // Instruction memory takes the low word
   } ext_mem_req_t;

endpackage

`default_nettype wire

/* stage_reg.sv */
/*
 * Pipeline register
 * Holds its payload when en is low, loads zeros (a bubble)
 * when en and clear are both high
 */
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
   parameter type payload_t = logic
) (
   input  wire logic clk,
   input  wire logic rst,
   input  wire logic en,
   input  wire logic clear,
   input  payload_t  d,
   output payload_t  q
);

   always_ff @(posedge clk) begin
      if (rst) begin
         q <= '0;
      end else if (en) begin
         q <= clear ? payload_t'('0) : d; // Bubble has all control inactive
      end
   end

endmodule

`default_nettype wire

/* mem_array.sv */
/*
 * Word-addressed memory array
 * Combinational core read, core write at the clock edge, and an
 * external port with edge write and registered read
 */
`timescale 1ns/1ps
`default_nettype none

module mem_array #(
   parameter int ADDR_W = 9,
   parameter int DATA_W = 32
) (
   input  wire logic                clk,
   input  rv_isa_pkg::xlen_t        core_addr,
   input  wire logic                core_wen,
   input  wire logic [DATA_W-1:0]   core_wdata,
   output logic [DATA_W-1:0]        core_rdata,
   input  pipe_pkg::ext_mem_req_t   ext,
   output logic [DATA_W-1:0]        ext_rdata
);

   localparam int OFFS = $clog2(DATA_W / 8); // Byte offset bits

   logic [DATA_W-1:0] mem [2**ADDR_W];
   logic [ADDR_W-1:0] core_idx;
   logic [ADDR_W-1:0] ext_idx;
   logic [DATA_W-1:0] ext_rdata_q = '0; // Power-up value

   assign core_idx = core_addr[OFFS +: ADDR_W];
   assign ext_idx  = ext.addr[OFFS +: ADDR_W];

   assign core_rdata = mem[core_idx];

   // External write is last, so it wins on the same word
   always_ff @(posedge clk) begin
      if (core_wen) begin
         mem[core_idx] <= core_wdata;
      end
      if (ext.wen) begin
         mem[ext_idx] <= ext.wdata[DATA_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (ext.ren) begin
         ext_rdata_q <= mem[ext_idx]; // Held until the next read
      end
   end

   assign ext_rdata = ext_rdata_q;

endmodule

`default_nettype wire

/* fetch_stage.sv */
/*
 * Fetch stage
 * Program counter and instruction memory
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
   parameter int IMEM_ADDR_W = 9
) (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       advance,
   input  pipe_pkg::ext_mem_req_t          ext,
   output rv_isa_pkg::instr_t              instr,
   output logic [rv_isa_pkg::INSTR_W-1:0]  ext_rdata
);

   import rv_isa_pkg::*;

   xlen_t pc;

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= '0;
      end else if (advance) begin
         pc <= pc + XLEN'(4); // Held on stall or disable
      end
   end

   mem_array #(
      .ADDR_W(IMEM_ADDR_W),
      .DATA_W(INSTR_W)
   ) u_imem (
      .clk       (clk),
      .core_addr (pc),
      .core_wen  (1'b0),
      .core_wdata('0),
      .core_rdata(instr),
      .ext       (ext),
      .ext_rdata (ext_rdata)
   );

endmodule

`default_nettype wire

/* decode_stage.sv */
/*
 * Decode stage
 * Register file with write bypass, control decode, immediate
 * extension and load-use hazard detection
 */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  wire logic            clk,
   input  wire logic            rst,
   input  rv_isa_pkg::instr_t   instr,
   input  rv_isa_pkg::reg_addr_t ex_load_rd,
   input  wire logic            ex_is_load,
   input  pipe_pkg::wb_port_t   wb,
   output pipe_pkg::id_ex_t     id_ex,
   output logic                 stall
);

   import rv_isa_pkg::*;
   import pipe_pkg::*;

   xlen_t      rf [32];
   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t  rs1;
   reg_addr_t  rs2;
   reg_addr_t  rd;
   ctrl_t      ctrl;
   xlen_t      rs1_data;
   xlen_t      rs2_data;
   xlen_t      imm;
   logic       uses_rs1;
   logic       uses_rs2;

   assign opcode = instr[6:0];
   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign funct7 = instr[31:25];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            rf[i] <= '0;
         end
      end else if (wb.reg_write && wb.rd != '0) begin
         rf[wb.rd] <= wb.data;
      end
   end

   // x0 reads zero, same-cycle write is passed through
   assign rs1_data = (rs1 == '0) ? '0 :
                     (wb.reg_write && wb.rd == rs1) ? wb.data : rf[rs1];
   assign rs2_data = (rs2 == '0) ? '0 :
                     (wb.reg_write && wb.rd == rs2) ? wb.data : rf[rs2];

   // Any other opcode or function code leaves all control inactive
   always_comb begin
      ctrl = '0;
      case (opcode)
         OPC_OP: begin
            if ((funct7 == F7_BASE && (funct3 == F3_ADD_SUB || funct3 == F3_XOR ||
                                       funct3 == F3_OR || funct3 == F3_AND)) ||
                (funct7 == F7_SUB && funct3 == F3_ADD_SUB)) begin
               ctrl.reg_write = 1'b1;
               ctrl.alu_class = ALU_CLASS_REG;
            end
         end
         OPC_OP_IMM: begin
            if (funct3 == F3_ADD_SUB) begin // addi only
               ctrl.reg_write = 1'b1;
               ctrl.alu_src   = 1'b1;
               ctrl.alu_class = ALU_CLASS_IMM;
            end
         end
         OPC_LOAD: begin
            if (funct3 == F3_DWORD) begin
               ctrl.reg_write  = 1'b1;
               ctrl.mem_to_reg = 1'b1;
               ctrl.mem_read   = 1'b1;
               ctrl.alu_src    = 1'b1;
            end
         end
         OPC_STORE: begin
            if (funct3 == F3_DWORD) begin
               ctrl.mem_write = 1'b1;
               ctrl.alu_src   = 1'b1;
            end
         end
         default: ctrl = '0;
      endcase
   end

   // S-type splits the offset around rd
   assign imm = (opcode == OPC_STORE) ?
                {{52{instr[31]}}, instr[31:25], instr[11:7]} :
                {{52{instr[31]}}, instr[31:20]};

   assign uses_rs1 = ctrl.reg_write | ctrl.mem_write;
   assign uses_rs2 = (ctrl.alu_class == ALU_CLASS_REG); // Store rs2 is covered in MEM

   assign stall = ex_is_load && ex_load_rd != '0 &&
                  ((uses_rs1 && ex_load_rd == rs1) || (uses_rs2 && ex_load_rd == rs2));

   always_comb begin
      id_ex.ctrl     = ctrl;
      id_ex.rs1_data = rs1_data;
      id_ex.rs2_data = rs2_data;
      id_ex.imm      = imm;
      id_ex.funct3   = funct3;
      id_ex.funct7   = funct7;
      id_ex.rs1      = rs1;
      id_ex.rs2      = rs2;
      id_ex.rd       = rd;
   end

endmodule

`default_nettype wire

/* execute_stage.sv */
/*
 * Execute stage
 * Operand forwarding from MEM and WB, operand B select,
 * ALU control and the 64-bit ALU
 */
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  pipe_pkg::id_ex_t   id_ex,
   input  pipe_pkg::wb_port_t mem_fwd,
   input  pipe_pkg::wb_port_t wb_fwd,
   output pipe_pkg::ex_mem_t  ex_mem
);

   import rv_isa_pkg::*;
   import pipe_pkg::*;

   xlen_t   op_a;
   xlen_t   rs2_fwd;
   xlen_t   op_b;
   xlen_t   result;
   alu_op_e alu_op;

   // Newest producer first, x0 never forwards
   function automatic xlen_t fwd_value(reg_addr_t rs, xlen_t rf_val,
                                       wb_port_t m, wb_port_t w);
      if (rs == '0) begin
         return rf_val;
      end
      if (m.reg_write && m.rd == rs) begin
         return m.data;
      end
      if (w.reg_write && w.rd == rs) begin
         return w.data;
      end
      return rf_val;
   endfunction

   assign op_a    = fwd_value(id_ex.rs1, id_ex.rs1_data, mem_fwd, wb_fwd);
   assign rs2_fwd = fwd_value(id_ex.rs2, id_ex.rs2_data, mem_fwd, wb_fwd);
   assign op_b    = id_ex.ctrl.alu_src ? id_ex.imm : rs2_fwd;

   always_comb begin
      alu_op = ALU_ADD; // addi and the ld/sd base plus offset
      if (id_ex.ctrl.alu_class == ALU_CLASS_REG) begin
         case (id_ex.funct3)
            F3_ADD_SUB: alu_op = (id_ex.funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
            F3_XOR:     alu_op = ALU_XOR;
            F3_OR:      alu_op = ALU_OR;
            F3_AND:     alu_op = ALU_AND;
            default:    alu_op = ALU_ADD;
         endcase
      end
   end

   always_comb begin
      case (alu_op)
         ALU_ADD: result = op_a + op_b;
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR:  result = op_a | op_b;
         ALU_XOR: result = op_a ^ op_b;
         default: result = '0;
      endcase
   end

   always_comb begin
      ex_mem.ctrl       = id_ex.ctrl;
      ex_mem.alu_result = result;
      ex_mem.store_data = rs2_fwd; // Forwarded, not the raw regfile value
      ex_mem.rs2        = id_ex.rs2;
      ex_mem.rd         = id_ex.rd;
   end

endmodule

`default_nettype wire

/* mem_stage.sv */
/*
 * Memory stage
 * Data memory access, with a load in WB forwarded into the
 * data of the store that follows it
 */
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
   parameter int DMEM_ADDR_W = 10
) (
   input  wire logic             clk,
   input  pipe_pkg::ex_mem_t     ex_mem,
   input  pipe_pkg::wb_port_t    wb_load,
   input  pipe_pkg::ext_mem_req_t ext,
   output rv_isa_pkg::xlen_t     load_data,
   output rv_isa_pkg::xlen_t     ext_rdata
);

   import rv_isa_pkg::*;

   xlen_t store_data;

   // ld directly followed by sd of the loaded register
   assign store_data = (wb_load.reg_write && wb_load.rd != '0 && wb_load.rd == ex_mem.rs2) ?
                       wb_load.data : ex_mem.store_data;

   mem_array #(
      .ADDR_W(DMEM_ADDR_W),
      .DATA_W(XLEN)
   ) u_dmem (
      .clk       (clk),
      .core_addr (ex_mem.alu_result),
      .core_wen  (ex_mem.ctrl.mem_write),
      .core_wdata(store_data),
      .core_rdata(load_data),
      .ext       (ext),
      .ext_rdata (ext_rdata)
   );

endmodule

`default_nettype wire

/* cpu.sv */
/*
 * RV64I five-stage pipeline top level
 * Connects fetch, decode, execute and memory stages through the
 * pipeline registers and selects the write-back data
 */
`timescale 1ns/1ps
`default_nettype none

module cpu #(
   parameter int IMEM_ADDR_W = 9,
   parameter int DMEM_ADDR_W = 10
) (
   input  wire logic                       clk,
   input  wire logic                       rst,
   input  wire logic                       enable,
   input  pipe_pkg::ext_mem_req_t          imem_ext,
   input  pipe_pkg::ext_mem_req_t          dmem_ext,
   output logic [rv_isa_pkg::INSTR_W-1:0]  imem_rdata,
   output rv_isa_pkg::xlen_t               dmem_rdata
);

   import rv_isa_pkg::*;
   import pipe_pkg::*;

   logic     stall;
   logic     advance;
   instr_t   if_instr;
   instr_t   if_id_q;
   id_ex_t   id_ex_d;
   id_ex_t   id_ex_q;
   ex_mem_t  ex_mem_d;
   ex_mem_t  ex_mem_q;
   ex_mem_t  ex_mem_act;
   mem_wb_t  mem_wb_d;
   mem_wb_t  mem_wb_q;
   xlen_t    load_data;
   xlen_t    wb_data;
   wb_port_t mem_fwd;
   wb_port_t wb_fwd;
   wb_port_t wb_load;

   assign advance = enable & ~stall; // PC and IF/ID hold on stall

   fetch_stage #(.IMEM_ADDR_W(IMEM_ADDR_W)) u_fetch (
      .clk      (clk),
      .rst      (rst),
      .advance  (advance),
      .ext      (imem_ext),
      .instr    (if_instr),
      .ext_rdata(imem_rdata)
   );

   stage_reg #(.payload_t(instr_t)) u_if_id (
      .clk(clk), .rst(rst), .en(advance), .clear(1'b0), .d(if_instr), .q(if_id_q)
   );

   decode_stage u_decode (
      .clk       (clk),
      .rst       (rst),
      .instr     (if_id_q),
      .ex_load_rd(id_ex_q.rd),
      .ex_is_load(id_ex_q.ctrl.mem_read & enable), // No stall while frozen
      .wb        (wb_fwd),
      .id_ex     (id_ex_d),
      .stall     (stall)
   );

   stage_reg #(.payload_t(id_ex_t)) u_id_ex (
      .clk(clk), .rst(rst), .en(enable), .clear(stall), .d(id_ex_d), .q(id_ex_q)
   );

   execute_stage u_execute (
      .id_ex  (id_ex_q),
      .mem_fwd(mem_fwd),
      .wb_fwd (wb_fwd),
      .ex_mem (ex_mem_d)
   );

   stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
      .clk(clk), .rst(rst), .en(enable), .clear(1'b0), .d(ex_mem_d), .q(ex_mem_q)
   );

   // A store parked in MEM must not write while the core is frozen
   always_comb begin
      ex_mem_act                = ex_mem_q;
      ex_mem_act.ctrl.mem_write = ex_mem_q.ctrl.mem_write & enable;
   end

   mem_stage #(.DMEM_ADDR_W(DMEM_ADDR_W)) u_mem (
      .clk      (clk),
      .ex_mem   (ex_mem_act),
      .wb_load  (wb_load),
      .ext      (dmem_ext),
      .load_data(load_data),
      .ext_rdata(dmem_rdata)
   );

   always_comb begin
      mem_wb_d.reg_write  = ex_mem_q.ctrl.reg_write;
      mem_wb_d.mem_to_reg = ex_mem_q.ctrl.mem_to_reg;
      mem_wb_d.mem_read   = ex_mem_q.ctrl.mem_read;
      mem_wb_d.load_data  = load_data;
      mem_wb_d.alu_result = ex_mem_q.alu_result;
      mem_wb_d.rd         = ex_mem_q.rd;
   end

   stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
      .clk(clk), .rst(rst), .en(enable), .clear(1'b0), .d(mem_wb_d), .q(mem_wb_q)
   );

   assign wb_data = mem_wb_q.mem_to_reg ? mem_wb_q.load_data : mem_wb_q.alu_result;

   // Write-back offers
   assign mem_fwd = '{reg_write: ex_mem_q.ctrl.reg_write, rd: ex_mem_q.rd,
                      data: ex_mem_q.alu_result};
   assign wb_fwd  = '{reg_write: mem_wb_q.reg_write, rd: mem_wb_q.rd, data: wb_data};
   assign wb_load = '{reg_write: mem_wb_q.reg_write & mem_wb_q.mem_read,
                      rd: mem_wb_q.rd, data: mem_wb_q.load_data};

endmodule

`default_nettype wire

/* cpu_sva.sv */
/*
 * Pipeline assertions bound into cpu
 * Stall length, bubble insertion, freeze and external read timing
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_sva (
   input wire logic                       clk,
   input wire logic                       rst,
   input wire logic                       enable,
   input wire logic                       stall,
   input rv_isa_pkg::instr_t              if_id_q,
   input pipe_pkg::id_ex_t                id_ex_q,
   input pipe_pkg::ex_mem_t               ex_mem_q,
   input pipe_pkg::mem_wb_t               mem_wb_q,
   input pipe_pkg::ext_mem_req_t          imem_ext,
   input pipe_pkg::ext_mem_req_t          dmem_ext,
   input logic [rv_isa_pkg::INSTR_W-1:0]  imem_rdata,
   input rv_isa_pkg::xlen_t               dmem_rdata
);

   a_stall_once: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
      else $error("load-use stall lasted two cycles");

   a_bubble: assert property (@(posedge clk) disable iff (rst) stall |=> id_ex_q.ctrl == '0)
      else $error("no bubble in ID/EX after a stall");

   a_frozen: assert property (@(posedge clk) disable iff (rst)
      !enable |=> ($stable(if_id_q) && $stable(id_ex_q) && $stable(ex_mem_q) &&
                   $stable(mem_wb_q)))
      else $error("pipeline register changed while disabled");

   a_imem_rd: assert property (@(posedge clk) disable iff (rst)
      !$stable(imem_rdata) |-> $past(imem_ext.ren))
      else $error("imem rdata changed without a read");

   a_dmem_rd: assert property (@(posedge clk) disable iff (rst)
      !$stable(dmem_rdata) |-> $past(dmem_ext.ren))
      else $error("dmem rdata changed without a read");

endmodule

bind cpu cpu_sva u_sva (
   .clk       (clk),
   .rst       (rst),
   .enable    (enable),
   .stall     (stall),
   .if_id_q   (if_id_q),
   .id_ex_q   (id_ex_q),
   .ex_mem_q  (ex_mem_q),
   .mem_wb_q  (mem_wb_q),
   .imem_ext  (imem_ext),
   .dmem_ext  (dmem_ext),
   .imem_rdata(imem_rdata),
   .dmem_rdata(dmem_rdata)
);

`default_nettype wire

/* tb_cpu.sv */
/*
 * Testbench for the five-stage RV64I pipeline
 * Loads programs and data through the external memory ports,
 * runs each test from reset and reads back the stored results
 */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

   import rv_isa_pkg::*;
   import pipe_pkg::*;

   localparam string STIM_FILE = "cpu_stim.txt";

   logic                clk;
   logic                rst;
   logic                enable;
   ext_mem_req_t        imem_ext;
   ext_mem_req_t        dmem_ext;
   logic [INSTR_W-1:0]  imem_rdata;
   xlen_t               dmem_rdata;

   // One entry per stimulus record and the test it belongs to
   logic [8*32-1:0] names [$];
   byte             kinds [$];
   xlen_t           addrs [$];
   xlen_t           vals  [$];
   int              owner [$];

   int cycles = 0;
   int limit  = 0;
   int errors = 0;
   int test_errs;
   int passed = 0;
   int failed = 0;

   cpu #(
      .IMEM_ADDR_W(9),
      .DMEM_ADDR_W(10)
   ) u_dut (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .imem_ext  (imem_ext),
      .dmem_ext  (dmem_ext),
      .imem_rdata(imem_rdata),
      .dmem_rdata(dmem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (limit != 0 && cycles > limit) begin
         $display("Run stopped after %0d cycles, a test did not finish", cycles);
         $display("test failed");
         $finish;
      end
   end

   // Inputs change 1 ns after the edge
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic add_record(input byte k, input xlen_t a, input xlen_t v, input int t);
      kinds.push_back(k);
      addrs.push_back(a);
      vals.push_back(v);
      owner.push_back(t);
   endtask

   task automatic read_stim();
      int              fd;
      int              r;
      int              t;
      logic [8*32-1:0] tok;
      logic [8*128-1:0] rest;
      xlen_t           a;
      xlen_t           v;
      t  = -1;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the stimulus file %0s", STIM_FILE);
         errors++;
         return;
      end
      while (!$feof(fd)) begin
         r = $fscanf(fd, "%s", tok);
         if (r != 1) break;
         if (tok == "#") begin
            r = $fgets(rest, fd);
         end else if (tok == "T") begin
            r = $fscanf(fd, "%s", tok);
            names.push_back(tok);
            t++;
         end else if (tok == "R") begin
            r = $fscanf(fd, "%d", v);
            add_record("R", '0, v, t);
         end else if (tok == "I" || tok == "D" || tok == "E") begin
            r = $fscanf(fd, "%h %h", a, v);
            add_record(tok[7:0], a, v, t);
         end else begin
            $display("Unknown line kind %0s in the stimulus file", tok);
            errors++;
            r = $fgets(rest, fd);
         end
      end
      $fclose(fd);
   endtask

   // Highest instruction word index a test loads
   function automatic int max_word(input int t);
      int top;
      top = 0;
      foreach (kinds[i]) begin
         if (owner[i] == t && kinds[i] == "I" && int'(addrs[i] >> 2) > top) begin
            top = int'(addrs[i] >> 2);
         end
      end
      return top;
   endfunction

   // Words filled with no-ops, enough for every fetch of the run
   function automatic int fill_words(input int t);
      int n;
      n = max_word(t) + 1;
      foreach (kinds[i]) begin
         if (owner[i] == t && kinds[i] == "R") begin
            n += int'(vals[i]);
         end
      end
      return n;
   endfunction

   // Load, reset, run and readback cycles of one test
   function automatic int test_cycles(input int t);
      int n;
      n = fill_words(t) + 2;
      foreach (kinds[i]) begin
         if (owner[i] == t) begin
            case (kinds[i])
               "I":     n += 2;
               "R":     n += int'(vals[i]);
               default: n += 1;
            endcase
         end
      end
      return n;
   endfunction

   task automatic ext_write(input bit to_imem, input xlen_t addr, input xlen_t data);
      if (to_imem) begin
         imem_ext.addr  = addr;
         imem_ext.wdata = data;
         imem_ext.wen   = 1'b1;
      end else begin
         dmem_ext.addr  = addr;
         dmem_ext.wdata = data;
         dmem_ext.wen   = 1'b1;
      end
      tick();
      imem_ext.wen = 1'b0;
      dmem_ext.wen = 1'b0;
   endtask

   // Data is on the rdata output one cycle after ren
   task automatic ext_read(input bit from_imem, input xlen_t addr, output xlen_t data);
      if (from_imem) begin
         imem_ext.addr = addr;
         imem_ext.ren  = 1'b1;
      end else begin
         dmem_ext.addr = addr;
         dmem_ext.ren  = 1'b1;
      end
      tick();
      imem_ext.ren = 1'b0;
      dmem_ext.ren = 1'b0;
      data = from_imem ? {32'b0, imem_rdata} : dmem_rdata;
   endtask

   task automatic check_value(input logic [8*32-1:0] name, input xlen_t addr,
                              input xlen_t exp, input xlen_t act);
      if (exp !== act) begin
         $display("[FAIL] %0s: addr %h expected %h actual %h", name, addr, exp, act);
         test_errs++;
      end
   endtask

   task automatic run_test(input int t);
      xlen_t got;
      xlen_t wa;
      int    nfill;
      test_errs = 0;
      enable    = 1'b0;
      nfill     = fill_words(t);
      // addi x0, x0, imm with the byte address as imm
      for (int w = 0; w < nfill; w++) begin
         wa = xlen_t'(w * 4);
         ext_write(1'b1, wa, {32'b0, wa[11:0], 20'h00013});
      end
      foreach (kinds[i]) begin
         if (owner[i] == t && kinds[i] == "I") ext_write(1'b1, addrs[i], vals[i]);
         if (owner[i] == t && kinds[i] == "D") ext_write(1'b0, addrs[i], vals[i]);
      end
      foreach (kinds[i]) begin
         if (owner[i] == t && kinds[i] == "I") begin
            ext_read(1'b1, addrs[i], got);
            check_value(names[t], addrs[i], {32'b0, vals[i][31:0]}, got);
         end
      end
      rst = 1'b1;
      tick();
      tick();
      rst = 1'b0;
      foreach (kinds[i]) begin
         if (owner[i] == t && kinds[i] == "R") begin
            enable = 1'b1;
            repeat (int'(vals[i])) tick();
            enable = 1'b0;
         end
      end
      foreach (kinds[i]) begin
         if (owner[i] == t && kinds[i] == "E") begin
            ext_read(1'b0, addrs[i], got);
            check_value(names[t], addrs[i], vals[i], got);
         end
      end
      if (test_errs == 0) begin
         $display("%0s: ok", names[t]);
         passed++;
      end else begin
         $display("%0s: %0d errors", names[t], test_errs);
         failed++;
      end
      errors += test_errs;
   endtask

   initial begin
      rst      = 1'b1;
      enable   = 1'b0;
      imem_ext = '0;
      dmem_ext = '0;
      read_stim();
      limit = 8 + 100; // Reset plus margin
      foreach (names[t]) begin
         limit += test_cycles(t);
      end
      repeat (8) tick();
      rst = 1'b0;
      foreach (names[t]) begin
         run_test(t);
      end
      $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, errors);
      if (errors == 0 && failed == 0 && names.size() > 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* cpu_stim.txt */
# T name | I byte_addr instr_hex | D byte_addr data_hex | R run_cycles | E byte_addr expected_hex
# Instruction words not listed are filled with no-ops
T ext_port
I 40 a5a5f00d
D 200 1122334455667788
R 0
E 200 1122334455667788
T alu_spaced
I 00 06400093
I 10 ff900113
I 20 002081b3
I 30 40208233
I 40 0020f2b3
I 50 0020e333
I 60 0020c3b3
I 70 00303023
I 80 00403423
I 90 00503823
I a0 00603c23
I b0 02703023
R 64
E 00 000000000000005d
E 08 000000000000006b
E 10 0000000000000060
E 18 fffffffffffffffd
E 20 ffffffffffffff9d
T fwd_chain
I 00 06400093
I 04 ff908113
I 08 001101b3
I 0c 40218233
I 10 003242b3
I 14 0042e333
I 18 001373b3
I 1c 00703023
I 20 00203423
I 24 00303823
I 28 00403c23
I 2c 02503023
I 30 02603423
R 28
E 00 0000000000000064
E 08 000000000000005d
E 10 00000000000000c1
E 18 0000000000000064
E 20 00000000000000a5
E 28 00000000000000e5
T load_use
D 100 0123456789abcdef
I 00 10003083
I 04 00108133
I 08 10203823
R 16
E 110 02468acf13579bde
T store_fwd
D 108 0000000000000005
I 00 10803183
I 04 10303c23
R 16
E 118 0000000000000005
T bad_opcode
D 00 000000000000bad0
D 08 000000000000bad8
I 00 06400093
I 04 00103023
I 08 fff080fb
I 0c 00103423
R 16
E 00 0000000000000064
E 08 0000000000000064

/* list.f */
rv_isa_pkg.sv
pipe_pkg.sv
stage_reg.sv
mem_array.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
mem_stage.sv
cpu.sv
cpu_sva.sv
tb_cpu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cpu testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f list.f -o Vtb_cpu
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_cpu > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -q "test failed" sim.log; then
   exit 1
fi
if ! grep -q "test passed" sim.log; then
   echo "No result line in sim.log"
   exit 1
fi
exit 0
